//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module track_collision_tb \
    -f sources.f \
    -o track_collision_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/track_collision_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- sources.f
verilog/track_pkg.sv
verilog/query_fifo.sv
verilog/segment_decode.sv
verilog/segment_execute.sv
verilog/collision_result.sv
verilog/track_collision_top.sv
verification/track_collision_chk.sv
verification/track_collision_tb.sv

//--- verification/track_collision_chk.sv
`timescale 1ns/1ps
`default_nettype none

module track_collision_chk (
    input logic                             i_clk,
    input logic                             i_reset,
    input logic                             i_push,
    input logic                             i_credit,
    input logic                             i_result_valid,
    input logic [track_pkg::CREDIT_W-1:0]   i_queue_count
);

    // a sender holding no credit never pushes, so a full queue sees no push
    no_push_when_full: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_push && (i_queue_count == track_pkg::CREDIT_W'(track_pkg::QUEUE_DEPTH)))
    ) else $error("query pushed while the queue holds QUEUE_DEPTH entries");

    quiet_after_reset: assert property (
        @(posedge i_clk)
        $past(i_reset) |-> (!i_result_valid && !i_credit)
    ) else $error("result valid or credit high in the cycle after reset");

    // credit leaves with the popped entry, which reaches the result four cycles later
    credit_yields_result: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_credit |-> ##4 i_result_valid
    ) else $error("credit returned without a result four cycles later");

endmodule

`default_nettype wire

//--- verification/track_collision_tb.sv
`timescale 1ns/1ps
`default_nettype none

module track_collision_tb;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 1;
    localparam int RESET_CYCLES     = 5;
    localparam int DIRECTED_QUERIES = 32;
    localparam int BURST_QUERIES    = 16;
    localparam int RANDOM_QUERIES   = 2000;
    localparam int TOTAL_QUERIES    = DIRECTED_QUERIES + BURST_QUERIES + RANDOM_QUERIES;
    localparam int RES_W            = track_pkg::SEG_COUNT + 2;

    logic                                   i_clk;
    logic                                   i_reset;
    logic                                   i_query_valid;
    logic signed [track_pkg::COORD_W-1:0]   i_x;
    logic signed [track_pkg::COORD_W-1:0]   i_y;
    logic signed [track_pkg::VEL_W-1:0]     i_v_x;
    logic signed [track_pkg::VEL_W-1:0]     i_v_y;
    logic        [track_pkg::RADIUS_W-1:0]  i_radius;
    logic                                   o_credit;
    logic                                   o_result_valid;
    logic                                   o_collision;
    logic                                   o_on_track;
    logic        [track_pkg::SEG_COUNT-1:0] o_region;

    // {collision, on_track, region} per outstanding query
    logic [RES_W-1:0] expected_q [$];
    int credits = track_pkg::QUEUE_DEPTH;
    int sent = 0;
    int received = 0;
    int returned = 0;
    int stall_cycles = 0;

    track_collision_top dut0 (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_query_valid  (i_query_valid),
        .i_x            (i_x),
        .i_y            (i_y),
        .i_v_x          (i_v_x),
        .i_v_y          (i_v_y),
        .i_radius       (i_radius),
        .o_credit       (o_credit),
        .o_result_valid (o_result_valid),
        .o_collision    (o_collision),
        .o_on_track     (o_on_track),
        .o_region       (o_region)
    );

    bind track_collision_top track_collision_chk chk0 (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_push         (i_query_valid),
        .i_credit       (o_credit),
        .i_result_valid (o_result_valid),
        .i_queue_count  (u_query_fifo.count)
    );

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // segment rules written out in plain integer arithmetic
    function automatic logic [RES_W-1:0] reference_result(
        input int x,
        input int y,
        input int vx,
        input int vy,
        input int r
    );
        logic [track_pkg::SEG_COUNT-1:0] region;
        logic [track_pkg::SEG_COUNT-1:0] band;
        logic [track_pkg::SEG_COUNT-1:0] hit;
        int pos;
        int lo;
        int hi;
        int vel;
        int dx;
        int dy;
        int d_sq;
        int dot;
        int r_in;
        int r_out;
        region = '0;
        band   = '0;
        hit    = '0;
        for (int s = 0; s < track_pkg::SEG_COUNT; s++) begin
            region[s] = (x >= int'(track_pkg::TRACK[s].x_left))
                     && (x <= int'(track_pkg::TRACK[s].x_right))
                     && (y >= int'(track_pkg::TRACK[s].y_bottom))
                     && (y <= int'(track_pkg::TRACK[s].y_top));
            if (track_pkg::TRACK[s].kind == track_pkg::SEG_ARC) begin
                dx    = x - int'(track_pkg::TRACK[s].center_x);
                dy    = y - int'(track_pkg::TRACK[s].center_y);
                d_sq  = dx * dx + dy * dy;
                dot   = dx * vx + dy * vy;
                r_in  = int'(track_pkg::TRACK[s].r_inner);
                r_out = int'(track_pkg::TRACK[s].r_outer);
                band[s] = region[s] && (d_sq > r_in * r_in) && (d_sq < r_out * r_out);
                hit[s]  = region[s]
                       && (((d_sq >= (r_out - r) * (r_out - r)) && (dot > 0))
                        || ((d_sq <= (r_in + r) * (r_in + r)) && (dot < 0)));
            end else begin
                // horizontal straights have their borders on y
                if (track_pkg::TRACK[s].kind == track_pkg::SEG_HORIZ) begin
                    pos = y;
                    lo  = int'(track_pkg::TRACK[s].y_bottom);
                    hi  = int'(track_pkg::TRACK[s].y_top);
                    vel = vy;
                end else begin
                    pos = x;
                    lo  = int'(track_pkg::TRACK[s].x_left);
                    hi  = int'(track_pkg::TRACK[s].x_right);
                    vel = vx;
                end
                band[s] = region[s] && (pos > lo) && (pos < hi);
                hit[s]  = region[s]
                       && (((pos + r >= hi) && (vel > 0)) || ((pos - r <= lo) && (vel < 0)));
            end
        end
        return {|hit, |band, region};
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_query(input int x, input int y, input int vx, input int vy,
                              input int r);
        while (credits == 0) begin
            stall_cycles++;
            next_cycle();
        end
        i_query_valid = 1'b1;
        i_x           = track_pkg::COORD_W'(x);
        i_y           = track_pkg::COORD_W'(y);
        i_v_x         = track_pkg::VEL_W'(vx);
        i_v_y         = track_pkg::VEL_W'(vy);
        i_radius      = track_pkg::RADIUS_W'(r);
        credits--;
        sent++;
        expected_q.push_back(reference_result(x, y, vx, vy, r));
        next_cycle();
        i_query_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        while ((expected_q.size() != 0) || (credits != track_pkg::QUEUE_DEPTH)) begin
            next_cycle();
        end
    endtask

    // points 10 inside each border with radius 20 moving toward and away
    task automatic straight_points(input int seg);
        logic horiz;
        int   lo;
        int   hi;
        int   mid;
        int   pos;
        int   vel;
        horiz = (track_pkg::TRACK[seg].kind == track_pkg::SEG_HORIZ);
        lo  = horiz ? int'(track_pkg::TRACK[seg].y_bottom) : int'(track_pkg::TRACK[seg].x_left);
        hi  = horiz ? int'(track_pkg::TRACK[seg].y_top) : int'(track_pkg::TRACK[seg].x_right);
        mid = horiz
            ? (int'(track_pkg::TRACK[seg].x_left) + int'(track_pkg::TRACK[seg].x_right)) / 2
            : (int'(track_pkg::TRACK[seg].y_bottom) + int'(track_pkg::TRACK[seg].y_top)) / 2;
        for (int side = 0; side < 2; side++) begin
            pos = (side == 0) ? hi - 10 : lo + 10;
            for (int dir = 0; dir < 2; dir++) begin
                vel = (dir == 0) ? 6 : -6;
                if (horiz) begin
                    send_query(mid, pos, 3, vel, 20);
                end else begin
                    send_query(pos, mid, vel, 3, 20);
                end
            end
        end
    endtask

    // diagonal steps around r_inner 100 and r_outer 215 with radius 20
    task automatic arc_points(input int seg, input int sx, input int sy);
        int steps [4];
        int cx;
        int cy;
        steps = '{80, 88, 135, 140};
        cx = int'(track_pkg::TRACK[seg].center_x);
        cy = int'(track_pkg::TRACK[seg].center_y);
        foreach (steps[i]) begin
            send_query(cx + sx * steps[i], cy + sy * steps[i], sx * 8, sy * 8, 20);
            send_query(cx + sx * steps[i], cy + sy * steps[i], -sx * 8, -sy * 8, 20);
        end
    endtask

    task automatic off_track_points();
        send_query(0, 0, 10, -10, 30);
        send_query(1500, 1500, -20, 5, 10);
        send_query(-2000, -2000, 7, 7, 63);
        send_query(1000, 0, 0, 0, 0);
        // in a box, outside the band
        send_query(-610, -210, 4, 4, 20);
        send_query(560, 180, -4, 4, 20);
        send_query(-10, -250, 0, 5, 20);
        send_query(630, 0, -5, 0, 20);
    endtask

    task automatic random_query();
        send_query(int'($urandom_range(1600)) - 800, int'($urandom_range(800)) - 400,
                   int'($urandom_range(255)) - 128, int'($urandom_range(255)) - 128,
                   int'($urandom_range(63)));
    endtask

    task automatic credit_burst();
        wait_for_drain();
        repeat (BURST_QUERIES) random_query();
        wait_for_drain();
        assert ((returned == sent) && (received == sent)) else begin
            $display("ERROR: %0d queries sent but %0d credits and %0d results came back",
                     sent, returned, received);
            stop_on_error();
        end
        // the queue pops every cycle, so a credit is back before the next send
        assert (stall_cycles == 0) else begin
            $display("ERROR: sender waited %0d cycles for credits while the queue drains",
                     stall_cycles);
            stop_on_error();
        end
    endtask

    initial begin : clock_gen
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(negedge i_clk) begin : count_credits
        if (!i_reset && o_credit) begin
            credits++;
            returned++;
            assert (credits <= track_pkg::QUEUE_DEPTH) else begin
                $display("ERROR: more credits returned than queries sent at %0t", $time);
                stop_on_error();
            end
        end
    end

    always @(negedge i_clk) begin : compare_results
        logic [RES_W-1:0] expected;
        if (o_result_valid) begin
            assert (expected_q.size() != 0) else begin
                $display("ERROR: result at %0t with no query outstanding", $time);
                stop_on_error();
            end
            expected = expected_q.pop_front();
            assert (o_collision == expected[RES_W-1]) else begin
                $display("MISMATCH at %0t: collision of result %0d, got %0b expected %0b",
                         $time, received, o_collision, expected[RES_W-1]);
                stop_on_error();
            end
            assert (o_on_track == expected[RES_W-2]) else begin
                $display("MISMATCH at %0t: on_track of result %0d, got %0b expected %0b",
                         $time, received, o_on_track, expected[RES_W-2]);
                stop_on_error();
            end
            assert (o_region == expected[track_pkg::SEG_COUNT-1:0]) else begin
                $display("MISMATCH at %0t: region of result %0d, got %h expected %h",
                         $time, received, o_region, expected[track_pkg::SEG_COUNT-1:0]);
                stop_on_error();
            end
            received++;
        end
    end

    initial begin : watchdog
        repeat (TOTAL_QUERIES * 20 + 100) @(posedge i_clk);
        $display("ERROR: timeout, results stopped arriving after %0d of %0d queries",
                 received, sent);
        stop_on_error();
    end

    initial begin : run_tests
        void'($urandom(32'ha90816d0));
        i_reset       = 1'b1;
        i_query_valid = 1'b0;
        i_x           = '0;
        i_y           = '0;
        i_v_x         = '0;
        i_v_y         = '0;
        i_radius      = '0;
        idle_cycles(RESET_CYCLES);
        i_reset = 1'b0;
        straight_points(0);
        straight_points(10);
        arc_points(1, -1, -1);
        arc_points(9, 1, 1);
        off_track_points();
        credit_burst();
        repeat (RANDOM_QUERIES) begin
            random_query();
            idle_cycles(int'($urandom_range(3)));
        end
        wait_for_drain();
        $display("%0d queries checked, %0d sender stall cycles", received, stall_cycles);
        if ((received == TOTAL_QUERIES) && (returned == sent) && (sent == TOTAL_QUERIES)) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("ERROR: %0d sent, %0d results, %0d credits, %0d planned",
                     sent, received, returned, TOTAL_QUERIES);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- verilog/collision_result.sv
`timescale 1ns/1ps
`default_nettype none

module collision_result (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_valid,
    input  logic [track_pkg::SEG_COUNT-1:0] i_in_box,
    input  logic [track_pkg::SEG_COUNT-1:0] i_in_band,
    input  logic [track_pkg::SEG_COUNT-1:0] i_hit,
    output logic                            o_result_valid,
    output logic                            o_collision,
    output logic                            o_on_track,
    output logic [track_pkg::SEG_COUNT-1:0] o_region
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_valid;
        end
    end

    // any segment is enough
    always_ff @(posedge i_clk) begin
        o_collision <= |i_hit;
        o_on_track  <= |i_in_band;
        o_region    <= i_in_box;
    end

endmodule

`default_nettype wire

//--- verilog/query_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module query_fifo (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_push,
    input  logic signed [track_pkg::COORD_W-1:0]   i_x,
    input  logic signed [track_pkg::COORD_W-1:0]   i_y,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_x,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_y,
    input  logic        [track_pkg::RADIUS_W-1:0]  i_radius,
    output logic                                   o_pop_valid,
    output logic signed [track_pkg::COORD_W-1:0]   o_x,
    output logic signed [track_pkg::COORD_W-1:0]   o_y,
    output logic signed [track_pkg::VEL_W-1:0]     o_v_x,
    output logic signed [track_pkg::VEL_W-1:0]     o_v_y,
    output logic        [track_pkg::RADIUS_W-1:0]  o_radius,
    output logic                                   o_credit
);

    logic signed [track_pkg::COORD_W-1:0]  mem_x [track_pkg::QUEUE_DEPTH];
    logic signed [track_pkg::COORD_W-1:0]  mem_y [track_pkg::QUEUE_DEPTH];
    logic signed [track_pkg::VEL_W-1:0]    mem_v_x [track_pkg::QUEUE_DEPTH];
    logic signed [track_pkg::VEL_W-1:0]    mem_v_y [track_pkg::QUEUE_DEPTH];
    logic        [track_pkg::RADIUS_W-1:0] mem_radius [track_pkg::QUEUE_DEPTH];

    logic [track_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [track_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [track_pkg::CREDIT_W-1:0]    count;
    logic                              pop;

    // drain one entry every cycle, credit goes back with it
    assign pop      = (count != '0);
    assign o_credit = pop;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_pop_valid <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count + track_pkg::CREDIT_W'(i_push) - track_pkg::CREDIT_W'(pop);
            o_pop_valid <= pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem_x[wr_ptr]      <= i_x;
            mem_y[wr_ptr]      <= i_y;
            mem_v_x[wr_ptr]    <= i_v_x;
            mem_v_y[wr_ptr]    <= i_v_y;
            mem_radius[wr_ptr] <= i_radius;
        end
        // head is registered on its way out
        if (pop) begin
            o_x      <= mem_x[rd_ptr];
            o_y      <= mem_y[rd_ptr];
            o_v_x    <= mem_v_x[rd_ptr];
            o_v_y    <= mem_v_y[rd_ptr];
            o_radius <= mem_radius[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/segment_decode.sv
`timescale 1ns/1ps
`default_nettype none

module segment_decode (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  logic signed [track_pkg::COORD_W-1:0]   i_x,
    input  logic signed [track_pkg::COORD_W-1:0]   i_y,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_x,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_y,
    input  logic        [track_pkg::RADIUS_W-1:0]  i_radius,
    output logic                                   o_valid,
    output logic signed [track_pkg::COORD_W-1:0]   o_x,
    output logic signed [track_pkg::COORD_W-1:0]   o_y,
    output logic signed [track_pkg::VEL_W-1:0]     o_v_x,
    output logic signed [track_pkg::VEL_W-1:0]     o_v_y,
    output logic        [track_pkg::RADIUS_W-1:0]  o_radius,
    output logic        [track_pkg::SEG_COUNT-1:0] o_in_box,
    output logic signed [track_pkg::COORD_W:0]     o_dx [track_pkg::SEG_COUNT],
    output logic signed [track_pkg::COORD_W:0]     o_dy [track_pkg::SEG_COUNT]
);

    logic        [track_pkg::SEG_COUNT-1:0] in_box;
    logic signed [track_pkg::COORD_W:0]     dx [track_pkg::SEG_COUNT];
    logic signed [track_pkg::COORD_W:0]     dy [track_pkg::SEG_COUNT];

    always_comb begin
        for (int s = 0; s < track_pkg::SEG_COUNT; s++) begin
            in_box[s] = (i_x >= track_pkg::TRACK[s].x_left)
                     && (i_x <= track_pkg::TRACK[s].x_right)
                     && (i_y >= track_pkg::TRACK[s].y_bottom)
                     && (i_y <= track_pkg::TRACK[s].y_top);
            // offsets only mean something for arcs
            if (track_pkg::TRACK[s].kind == track_pkg::SEG_ARC) begin
                dx[s] = (track_pkg::COORD_W+1)'(i_x)
                      - (track_pkg::COORD_W+1)'(track_pkg::TRACK[s].center_x);
                dy[s] = (track_pkg::COORD_W+1)'(i_y)
                      - (track_pkg::COORD_W+1)'(track_pkg::TRACK[s].center_y);
            end else begin
                dx[s] = '0;
                dy[s] = '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_x      <= i_x;
        o_y      <= i_y;
        o_v_x    <= i_v_x;
        o_v_y    <= i_v_y;
        o_radius <= i_radius;
        o_in_box <= in_box;
        o_dx     <= dx;
        o_dy     <= dy;
    end

endmodule

`default_nettype wire

//--- verilog/segment_execute.sv
`timescale 1ns/1ps
`default_nettype none

module segment_execute (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  logic signed [track_pkg::COORD_W-1:0]   i_x,
    input  logic signed [track_pkg::COORD_W-1:0]   i_y,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_x,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_y,
    input  logic        [track_pkg::RADIUS_W-1:0]  i_radius,
    input  logic        [track_pkg::SEG_COUNT-1:0] i_in_box,
    input  logic signed [track_pkg::COORD_W:0]     i_dx [track_pkg::SEG_COUNT],
    input  logic signed [track_pkg::COORD_W:0]     i_dy [track_pkg::SEG_COUNT],
    output logic                                   o_valid,
    output logic        [track_pkg::SEG_COUNT-1:0] o_in_box,
    output logic        [track_pkg::SEG_COUNT-1:0] o_in_band,
    output logic        [track_pkg::SEG_COUNT-1:0] o_hit
);

    function automatic logic [track_pkg::SQ_W-1:0] square(
        input logic signed [track_pkg::SQ_W-1:0] v
    );
        return v * v;
    endfunction

    // straight band along one axis, returns {in_band, hit}
    function automatic logic [1:0] straight_eval(
        input logic signed [track_pkg::COORD_W-1:0]  pos,
        input logic signed [track_pkg::COORD_W-1:0]  lo,
        input logic signed [track_pkg::COORD_W-1:0]  hi,
        input logic signed [track_pkg::VEL_W-1:0]    vel,
        input logic        [track_pkg::RADIUS_W-1:0] radius
    );
        logic signed [track_pkg::COORD_W+1:0] near_hi;
        logic signed [track_pkg::COORD_W+1:0] near_lo;
        logic                                 hit;
        near_hi = pos + $signed({1'b0, radius});
        near_lo = pos - $signed({1'b0, radius});
        hit = ((near_hi >= hi) && (vel > 0)) || ((near_lo <= lo) && (vel < 0));
        return {(pos > lo) && (pos < hi), hit};
    endfunction

    // quarter ring, moving away from the centre means positive dot
    function automatic logic [1:0] arc_eval(
        input track_pkg::segment_t                   seg,
        input logic signed [track_pkg::COORD_W:0]    dx,
        input logic signed [track_pkg::COORD_W:0]    dy,
        input logic signed [track_pkg::VEL_W-1:0]    v_x,
        input logic signed [track_pkg::VEL_W-1:0]    v_y,
        input logic        [track_pkg::RADIUS_W-1:0] radius
    );
        logic        [track_pkg::SQ_W-1:0]                d_sq;
        logic signed [track_pkg::COORD_W+track_pkg::VEL_W+1:0] dot;
        logic signed [track_pkg::COORD_W+1:0]             r_out_less;
        logic signed [track_pkg::COORD_W+1:0]             r_in_more;
        logic                                             in_band;
        logic                                             hit;
        d_sq       = square(dx) + square(dy);
        dot        = dx * v_x + dy * v_y;
        r_out_less = $signed({2'b0, seg.r_outer}) - $signed({1'b0, radius});
        r_in_more  = $signed({2'b0, seg.r_inner}) + $signed({1'b0, radius});
        in_band = (d_sq > square($signed({2'b0, seg.r_inner})))
               && (d_sq < square($signed({2'b0, seg.r_outer})));
        hit = ((d_sq >= square(r_out_less)) && (dot > 0))
           || ((d_sq <= square(r_in_more)) && (dot < 0));
        return {in_band, hit};
    endfunction

    logic [1:0]                         res [track_pkg::SEG_COUNT];
    logic [track_pkg::SEG_COUNT-1:0]    in_band;
    logic [track_pkg::SEG_COUNT-1:0]    hit;

    always_comb begin
        for (int s = 0; s < track_pkg::SEG_COUNT; s++) begin
            case (track_pkg::TRACK[s].kind)
                track_pkg::SEG_HORIZ: res[s] = straight_eval(i_y,
                    track_pkg::TRACK[s].y_bottom, track_pkg::TRACK[s].y_top, i_v_y, i_radius);
                track_pkg::SEG_VERT: res[s] = straight_eval(i_x,
                    track_pkg::TRACK[s].x_left, track_pkg::TRACK[s].x_right, i_v_x, i_radius);
                default: res[s] = arc_eval(track_pkg::TRACK[s], i_dx[s], i_dy[s],
                    i_v_x, i_v_y, i_radius);
            endcase
            // nothing counts outside the bounding box
            in_band[s] = i_in_box[s] & res[s][1];
            hit[s]     = i_in_box[s] & res[s][0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_in_box  <= i_in_box;
        o_in_band <= in_band;
        o_hit     <= hit;
    end

endmodule

`default_nettype wire

//--- verilog/track_collision_top.sv
`timescale 1ns/1ps
`default_nettype none

module track_collision_top (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_query_valid,
    input  logic signed [track_pkg::COORD_W-1:0]   i_x,
    input  logic signed [track_pkg::COORD_W-1:0]   i_y,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_x,
    input  logic signed [track_pkg::VEL_W-1:0]     i_v_y,
    input  logic        [track_pkg::RADIUS_W-1:0]  i_radius,
    output logic                                   o_credit,
    output logic                                   o_result_valid,
    output logic                                   o_collision,
    output logic                                   o_on_track,
    output logic        [track_pkg::SEG_COUNT-1:0] o_region
);

    // queue to decode
    logic                                  pop_valid;
    logic signed [track_pkg::COORD_W-1:0]  pop_x;
    logic signed [track_pkg::COORD_W-1:0]  pop_y;
    logic signed [track_pkg::VEL_W-1:0]    pop_v_x;
    logic signed [track_pkg::VEL_W-1:0]    pop_v_y;
    logic        [track_pkg::RADIUS_W-1:0] pop_radius;

    // decode to execute
    logic                                   dec_valid;
    logic signed [track_pkg::COORD_W-1:0]   dec_x;
    logic signed [track_pkg::COORD_W-1:0]   dec_y;
    logic signed [track_pkg::VEL_W-1:0]     dec_v_x;
    logic signed [track_pkg::VEL_W-1:0]     dec_v_y;
    logic        [track_pkg::RADIUS_W-1:0]  dec_radius;
    logic        [track_pkg::SEG_COUNT-1:0] dec_in_box;
    logic signed [track_pkg::COORD_W:0]     dec_dx [track_pkg::SEG_COUNT];
    logic signed [track_pkg::COORD_W:0]     dec_dy [track_pkg::SEG_COUNT];

    // execute to result
    logic                            exe_valid;
    logic [track_pkg::SEG_COUNT-1:0] exe_in_box;
    logic [track_pkg::SEG_COUNT-1:0] exe_in_band;
    logic [track_pkg::SEG_COUNT-1:0] exe_hit;

    query_fifo u_query_fifo (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_push      (i_query_valid),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_v_x       (i_v_x),
        .i_v_y       (i_v_y),
        .i_radius    (i_radius),
        .o_pop_valid (pop_valid),
        .o_x         (pop_x),
        .o_y         (pop_y),
        .o_v_x       (pop_v_x),
        .o_v_y       (pop_v_y),
        .o_radius    (pop_radius),
        .o_credit    (o_credit)
    );

    segment_decode u_segment_decode (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_valid  (pop_valid),
        .i_x      (pop_x),
        .i_y      (pop_y),
        .i_v_x    (pop_v_x),
        .i_v_y    (pop_v_y),
        .i_radius (pop_radius),
        .o_valid  (dec_valid),
        .o_x      (dec_x),
        .o_y      (dec_y),
        .o_v_x    (dec_v_x),
        .o_v_y    (dec_v_y),
        .o_radius (dec_radius),
        .o_in_box (dec_in_box),
        .o_dx     (dec_dx),
        .o_dy     (dec_dy)
    );

    segment_execute u_segment_execute (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (dec_valid),
        .i_x       (dec_x),
        .i_y       (dec_y),
        .i_v_x     (dec_v_x),
        .i_v_y     (dec_v_y),
        .i_radius  (dec_radius),
        .i_in_box  (dec_in_box),
        .i_dx      (dec_dx),
        .i_dy      (dec_dy),
        .o_valid   (exe_valid),
        .o_in_box  (exe_in_box),
        .o_in_band (exe_in_band),
        .o_hit     (exe_hit)
    );

    collision_result u_collision_result (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_valid        (exe_valid),
        .i_in_box       (exe_in_box),
        .i_in_band      (exe_in_band),
        .i_hit          (exe_hit),
        .o_result_valid (o_result_valid),
        .o_collision    (o_collision),
        .o_on_track     (o_on_track),
        .o_region       (o_region)
    );

endmodule

`default_nettype wire

//--- verilog/track_pkg.sv
`default_nettype none

package track_pkg;

    localparam int COORD_W     = 12;
    localparam int VEL_W       = 8;
    localparam int RADIUS_W    = 6;
    localparam int SQ_W        = 26;
    localparam int SEG_COUNT   = 12;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;
    localparam int CREDIT_W    = 3;

    typedef enum logic [1:0] {
        SEG_HORIZ,
        SEG_VERT,
        SEG_ARC
    } seg_kind_t;

    // bounding box is inclusive on all four edges
    typedef struct packed {
        seg_kind_t                 kind;
        logic signed [COORD_W-1:0] x_left;
        logic signed [COORD_W-1:0] x_right;
        logic signed [COORD_W-1:0] y_top;
        logic signed [COORD_W-1:0] y_bottom;
        // arc geometry, zero on straights
        logic signed [COORD_W-1:0] center_x;
        logic signed [COORD_W-1:0] center_y;
        logic [COORD_W-1:0]        r_inner;
        logic [COORD_W-1:0]        r_outer;
    } segment_t;

    // the closed loop, in driving order
    localparam segment_t TRACK [SEG_COUNT] = '{
        '{kind: SEG_HORIZ, x_left: -550, x_right: 530, y_top: -250, y_bottom: -365,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: -770, x_right: -550, y_top: -150, y_bottom: -370,
          center_x: -550, center_y: -150, r_inner: 100, r_outer: 215},
        '{kind: SEG_VERT, x_left: -765, x_right: -650, y_top: 150, y_bottom: -150,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: -770, x_right: -330, y_top: 370, y_bottom: 150,
          center_x: -550, center_y: 150, r_inner: 100, r_outer: 215},
        '{kind: SEG_VERT, x_left: -450, x_right: -335, y_top: 150, y_bottom: 0,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: -455, x_right: -15, y_top: 0, y_bottom: -220,
          center_x: -235, center_y: 0, r_inner: 100, r_outer: 215},
        '{kind: SEG_VERT, x_left: -135, x_right: -20, y_top: 150, y_bottom: 0,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: -140, x_right: 80, y_top: 370, y_bottom: 150,
          center_x: 80, center_y: 150, r_inner: 100, r_outer: 215},
        '{kind: SEG_HORIZ, x_left: 80, x_right: 530, y_top: 365, y_bottom: 250,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: 530, x_right: 750, y_top: 370, y_bottom: 150,
          center_x: 530, center_y: 150, r_inner: 100, r_outer: 215},
        '{kind: SEG_VERT, x_left: 630, x_right: 745, y_top: 150, y_bottom: -150,
          center_x: 0, center_y: 0, r_inner: 0, r_outer: 0},
        '{kind: SEG_ARC, x_left: 530, x_right: 750, y_top: -150, y_bottom: -370,
          center_x: 530, center_y: -150, r_inner: 100, r_outer: 215}
    };

endpackage

`default_nettype wire
